// ==== Bender.yml ====
package:
  name: mm

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/mm_pkg.sv
      - rtl/mm_delay_pipe.sv
      - rtl/mm_mac_array.sv
      - rtl/mm_bias_fetch.sv
      - rtl/mm_sequencer.sv
      - rtl/mm_output_stage.sv
      - rtl/mm_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/mm_checker.sv
      - test/mm_tb.sv

// ==== include/mm_consts.svh ====
`ifndef MM_CONSTS_SVH
`define MM_CONSTS_SVH

// vector shape
`define MM_LANES 4
`define MM_ELEM_W 16

// memory address widths
`define MM_ADDR_W 11
`define MM_WADDR_W 13
`define MM_BADDR_W 9

// loop counter widths
`define MM_CNT_W 8
`define MM_NODE_W 16

// address-valid to data-valid, all read ports
`define MM_MEM_LAT 2

`endif

// ==== mm.f ====
+incdir+include
rtl/mm_pkg.sv
rtl/mm_delay_pipe.sv
rtl/mm_mac_array.sv
rtl/mm_bias_fetch.sv
rtl/mm_sequencer.sv
rtl/mm_output_stage.sv
rtl/mm_top.sv
test/mm_checker.sv
test/mm_tb.sv

// ==== rtl/mm_bias_fetch.sv ====
`timescale 1ns/10ps
`include "mm_consts.svh"

module mm_bias_fetch (
   input  logic             clk,
   input  logic             rstn,
   input  mm_pkg::vec_rsp_t bias_rsp,
   output mm_pkg::vec_t     bias_vec
);

   mm_pkg::vec_t bias_d;

   // only last-ci beats of bias jobs request bias,
   // so every other cycle contributes zero
   always_comb begin
      bias_d = '0;
      if (bias_rsp.valid) begin
         for (int j = 0; j < `MM_LANES; j++) begin
            bias_d[j] = bias_rsp.data[j];
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // one register stage, lines up with the mac output
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         bias_vec <= '0;
      end else begin
         bias_vec <= bias_d;
      end
   end

endmodule

// ==== rtl/mm_delay_pipe.sv ====
`timescale 1ns/10ps

module mm_delay_pipe #(
   parameter type T     = logic,
   parameter int  DEPTH = 1
) (
   input  logic clk,
   input  logic rstn,
   input  T     din,
   input  logic din_valid,
   output T     dout,
   output logic dout_valid
);

   T                 data_q [DEPTH];
   logic [DEPTH-1:0] valid_q;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         valid_q <= '0;
      end else begin
         valid_q[0] <= din_valid;
         for (int k = 1; k < DEPTH; k++) begin
            valid_q[k] <= valid_q[k-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      data_q[0] <= din;
      for (int k = 1; k < DEPTH; k++) begin
         data_q[k] <= data_q[k-1];
      end
   end

   assign dout       = data_q[DEPTH-1];
   assign dout_valid = valid_q[DEPTH-1];

endmodule

// ==== rtl/mm_mac_array.sv ====
`timescale 1ns/10ps
`include "mm_consts.svh"

module mm_mac_array (
   input  logic                clk,
   input  logic                rstn,
   input  mm_pkg::vec_rsp_t    input_rsp,
   input  mm_pkg::wblock_rsp_t weight_rsp,
   output mm_pkg::vec_t        prod,
   output logic                prod_valid
);

   mm_pkg::vec_t prod_d;

   // y[j] = sum over i of x[i]*w[i][j], wraps to element width
   always_comb begin
      prod_d = '0;
      for (int j = 0; j < `MM_LANES; j++) begin
         for (int i = 0; i < `MM_LANES; i++) begin
            prod_d[j] = prod_d[j] + input_rsp.data[i] * weight_rsp.data[i][j];
         end
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         prod_valid <= 1'b0;
      end else begin
         prod_valid <= input_rsp.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (input_rsp.valid) begin
         prod <= prod_d;
      end
   end

endmodule

// ==== rtl/mm_output_stage.sv ====
`timescale 1ns/10ps
`include "mm_consts.svh"

module mm_output_stage (
   input  logic                  clk,
   input  logic                  rstn,
   input  mm_pkg::mm_cfg_t       cfg,
   input  mm_pkg::vec_t          prod,
   input  logic                  prod_valid,
   input  mm_pkg::beat_tag_t     tag,
   input  mm_pkg::vec_t          bias_vec,
   output logic                  out_valid,
   output logic [`MM_ADDR_W-1:0] out_addr,
   output mm_pkg::vec_t          out_data,
   output logic                  done
);

   mm_pkg::vec_t acc_q;
   mm_pkg::vec_t sum_d;
   mm_pkg::vec_t res_d;
   logic         first_q;
   logic         last_q;
   logic         emit;

   assign emit = prod_valid && tag.last_ci;

   always_comb begin
      for (int j = 0; j < `MM_LANES; j++) begin
         sum_d[j] = acc_q[j] + prod[j];
         res_d[j] = sum_d[j] + bias_vec[j];
         // relu per lane
         if (cfg.relu_en && res_d[j][`MM_ELEM_W-1]) begin
            res_d[j] = '0;
         end
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         acc_q     <= '0;
         out_valid <= 1'b0;
         out_addr  <= '0;
         first_q   <= 1'b1;
         last_q    <= 1'b0;
         done      <= 1'b0;
      end else begin
         out_valid <= emit;
         last_q    <= prod_valid && tag.last_job;
         done      <= last_q;
         if (emit) begin
            acc_q    <= '0;
            out_addr <= first_q ? cfg.output_start : out_addr + 1'b1;
            // next output after the last one opens a new job
            first_q  <= tag.last_job;
         end else if (prod_valid) begin
            acc_q <= sum_d;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (emit) begin
         out_data <= res_d;
      end
   end

endmodule

// ==== rtl/mm_pkg.sv ====
`include "mm_consts.svh"

package mm_pkg;

   typedef logic signed [`MM_ELEM_W-1:0] elem_t;

   typedef elem_t [`MM_LANES-1:0] vec_t;

   // row i is the input lane, column j the output lane
   typedef vec_t [`MM_LANES-1:0] wblock_t;

   typedef struct packed {
      logic [`MM_ADDR_W-1:0]  input_start;
      logic [`MM_WADDR_W-1:0] weight_start;
      logic [`MM_BADDR_W-1:0] bias_start;
      logic [`MM_ADDR_W-1:0]  output_start;
      logic [`MM_CNT_W-1:0]   ci_count;
      logic [`MM_CNT_W-1:0]   co_count;
      logic [`MM_NODE_W-1:0]  node_count;
      logic                   bias_en;
      logic                   relu_en;
   } mm_cfg_t;

   typedef struct packed {
      logic last_ci;
      logic last_job;
   } beat_tag_t;

   // sized for the widest port, narrower ports zero-extend
   typedef struct packed {
      logic [`MM_WADDR_W-1:0] addr;
      logic                   valid;
   } rd_req_t;

   typedef struct packed {
      vec_t data;
      logic valid;
   } vec_rsp_t;

   typedef struct packed {
      wblock_t data;
      logic    valid;
   } wblock_rsp_t;

endpackage

// ==== rtl/mm_sequencer.sv ====
`timescale 1ns/10ps
`include "mm_consts.svh"

module mm_sequencer (
   input  logic             clk,
   input  logic             rstn,
   input  mm_pkg::mm_cfg_t  cfg,
   input  logic             start,
   output mm_pkg::rd_req_t  input_rd,
   output mm_pkg::rd_req_t  weight_rd,
   output mm_pkg::rd_req_t  bias_rd,
   output mm_pkg::beat_tag_t tag,
   output logic             tag_valid
);

   localparam int ADDR_W  = `MM_ADDR_W;
   localparam int WADDR_W = `MM_WADDR_W;
   localparam int BADDR_W = `MM_BADDR_W;

   logic                  busy;
   logic [`MM_CNT_W-1:0]  ci_q;
   logic [`MM_CNT_W-1:0]  co_q;
   logic [`MM_NODE_W-1:0] n_q;
   logic [ADDR_W-1:0]     in_addr_q;
   logic [WADDR_W-1:0]    w_addr_q;
   logic [BADDR_W-1:0]    b_addr;
   logic                  last_ci;
   logic                  last_co;
   logic                  last_n;
   logic                  last_beat;

   assign last_ci   = (ci_q == cfg.ci_count - 1'b1);
   assign last_co   = (co_q == cfg.co_count - 1'b1);
   assign last_n    = (n_q == cfg.node_count - 1'b1);
   assign last_beat = last_ci && last_co && last_n;
   assign b_addr    = cfg.bias_start + BADDR_W'(co_q);

   ///////////////////////////////////////////////////////////////////////
   // loop counters and address walks
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         busy      <= 1'b0;
         ci_q      <= '0;
         co_q      <= '0;
         n_q       <= '0;
         in_addr_q <= '0;
         w_addr_q  <= '0;
      end else if (!busy) begin
         if (start) begin
            busy      <= 1'b1;
            ci_q      <= '0;
            co_q      <= '0;
            n_q       <= '0;
            in_addr_q <= cfg.input_start;
            w_addr_q  <= cfg.weight_start;
         end
      end else if (last_beat) begin
         // counters hold after the final beat
         busy <= 1'b0;
      end else if (!last_ci) begin
         ci_q      <= ci_q + 1'b1;
         in_addr_q <= in_addr_q + 1'b1;
         w_addr_q  <= w_addr_q + 1'b1;
      end else if (!last_co) begin
         // same node again, next weight row
         ci_q      <= '0;
         co_q      <= co_q + 1'b1;
         in_addr_q <= in_addr_q - ADDR_W'(cfg.ci_count) + 1'b1;
         w_addr_q  <= w_addr_q + 1'b1;
      end else begin
         ci_q      <= '0;
         co_q      <= '0;
         n_q       <= n_q + 1'b1;
         in_addr_q <= in_addr_q + 1'b1;
         w_addr_q  <= cfg.weight_start;
      end
   end

   // requests follow the counter state directly
   always_comb begin
      input_rd.addr   = WADDR_W'(in_addr_q);
      input_rd.valid  = busy;
      weight_rd.addr  = w_addr_q;
      weight_rd.valid = busy;
      bias_rd.addr    = WADDR_W'(b_addr);
      bias_rd.valid   = busy && cfg.bias_en && last_ci;
      tag.last_ci     = last_ci;
      tag.last_job    = last_beat;
      tag_valid       = busy;
   end

endmodule

// ==== rtl/mm_top.sv ====
`timescale 1ns/10ps
`include "mm_consts.svh"

module mm_top (
   input  logic                   clk,
   input  logic                   rstn,
   input  mm_pkg::mm_cfg_t        cfg,
   input  logic                   start,
   output mm_pkg::rd_req_t        input_rd,
   input  mm_pkg::vec_rsp_t       input_rsp,
   output mm_pkg::rd_req_t        weight_rd,
   input  mm_pkg::wblock_rsp_t    weight_rsp,
   output mm_pkg::rd_req_t        bias_rd,
   input  mm_pkg::vec_rsp_t       bias_rsp,
   output logic                   out_valid,
   output logic [`MM_ADDR_W-1:0]  out_addr,
   output mm_pkg::vec_t           out_data,
   output logic                   done
);

   mm_pkg::beat_tag_t tag;
   logic              tag_valid;
   mm_pkg::beat_tag_t tag_d;
   mm_pkg::vec_t      prod;
   logic              prod_valid;
   mm_pkg::vec_t      bias_vec;

   mm_sequencer i_sequencer (
      .clk       (clk),
      .rstn      (rstn),
      .cfg       (cfg),
      .start     (start),
      .input_rd  (input_rd),
      .weight_rd (weight_rd),
      .bias_rd   (bias_rd),
      .tag       (tag),
      .tag_valid (tag_valid)
   );

   // tag rides along with the beat until its product is ready
   mm_delay_pipe #(
      .T     (mm_pkg::beat_tag_t),
      .DEPTH (`MM_MEM_LAT + 1)
   ) i_tag_pipe (
      .clk        (clk),
      .rstn       (rstn),
      .din        (tag),
      .din_valid  (tag_valid),
      .dout       (tag_d),
      .dout_valid ()
   );

   mm_mac_array i_mac_array (
      .clk        (clk),
      .rstn       (rstn),
      .input_rsp  (input_rsp),
      .weight_rsp (weight_rsp),
      .prod       (prod),
      .prod_valid (prod_valid)
   );

   mm_bias_fetch i_bias_fetch (
      .clk      (clk),
      .rstn     (rstn),
      .bias_rsp (bias_rsp),
      .bias_vec (bias_vec)
   );

   mm_output_stage i_output_stage (
      .clk        (clk),
      .rstn       (rstn),
      .cfg        (cfg),
      .prod       (prod),
      .prod_valid (prod_valid),
      .tag        (tag_d),
      .bias_vec   (bias_vec),
      .out_valid  (out_valid),
      .out_addr   (out_addr),
      .out_data   (out_data),
      .done       (done)
   );

endmodule

// ==== test/mm_checker.sv ====
`timescale 1ns/10ps
`include "mm_consts.svh"

module mm_checker (
   input logic            clk,
   input logic            rstn,
   input mm_pkg::mm_cfg_t cfg,
   input mm_pkg::rd_req_t input_rd,
   input mm_pkg::rd_req_t weight_rd,
   input mm_pkg::rd_req_t bias_rd,
   input logic            out_valid,
   input logic            done
);

   localparam int AW  = `MM_ADDR_W;
   localparam int WAW = `MM_WADDR_W;
   localparam int BAW = `MM_BADDR_W;

   int unsigned           fail_count = 0;
   logic [`MM_CNT_W-1:0]  ci;
   logic [`MM_CNT_W-1:0]  co;
   logic [`MM_NODE_W-1:0] n;
   logic                  ci_end;
   logic                  co_end;
   logic                  beat_end;
   logic [AW-1:0]         in_addr_exp;
   logic [WAW-1:0]        w_addr_exp;
   logic [BAW-1:0]        b_addr_exp;

   assign ci_end      = (ci == cfg.ci_count - 1'b1);
   assign co_end      = (co == cfg.co_count - 1'b1);
   assign beat_end    = ci_end && co_end && (n == cfg.node_count - 1'b1);
   assign in_addr_exp = cfg.input_start + AW'(n * cfg.ci_count) + AW'(ci);
   assign w_addr_exp  = cfg.weight_start + WAW'(co * cfg.ci_count) + WAW'(ci);
   assign b_addr_exp  = cfg.bias_start + BAW'(co);

   // own copy of the loop position, ci fastest, then co, then n
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         ci <= '0;
         co <= '0;
         n  <= '0;
      end else if (input_rd.valid) begin
         ci <= ci_end ? '0 : ci + 1'b1;
         if (ci_end) begin
            co <= co_end ? '0 : co + 1'b1;
         end
         if (ci_end && co_end) begin
            n <= beat_end ? '0 : n + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // address walks
   ////////////////////////////////////////////////////////////////////

   a_input_addr: assert property (@(posedge clk) disable iff (!rstn)
      input_rd.valid |-> input_rd.addr == WAW'(in_addr_exp))
      else begin
         fail_count++;
         $error("input address left the n*Ci+ci walk");
      end

   a_weight_addr: assert property (@(posedge clk) disable iff (!rstn)
      input_rd.valid |-> weight_rd.valid && weight_rd.addr == w_addr_exp)
      else begin
         fail_count++;
         $error("weight request missing or off the co*Ci+ci walk");
      end

   a_bias_req: assert property (@(posedge clk) disable iff (!rstn)
      bias_rd.valid == (input_rd.valid && cfg.bias_en && ci_end))
      else begin
         fail_count++;
         $error("bias request outside the last ci beat of a bias job");
      end

   a_bias_addr: assert property (@(posedge clk) disable iff (!rstn)
      bias_rd.valid |-> bias_rd.addr == WAW'(b_addr_exp))
      else begin
         fail_count++;
         $error("bias address is not bias_start+co");
      end

   ////////////////////////////////////////////////////////////////////
   // beat stream and output timing
   ////////////////////////////////////////////////////////////////////

   a_no_gap: assert property (@(posedge clk) disable iff (!rstn)
      input_rd.valid && !beat_end |=> input_rd.valid)
      else begin
         fail_count++;
         $error("gap in the beat stream");
      end

   a_stop: assert property (@(posedge clk) disable iff (!rstn)
      input_rd.valid && beat_end |=> !input_rd.valid)
      else begin
         fail_count++;
         $error("request issued after the final beat");
      end

   a_out_timing: assert property (@(posedge clk) disable iff (!rstn)
      out_valid == $past(input_rd.valid && ci_end, `MM_MEM_LAT + 2))
      else begin
         fail_count++;
         $error("out_valid not at last ci issue plus latency");
      end

   a_done: assert property (@(posedge clk) disable iff (!rstn)
      done == $past(input_rd.valid && beat_end, `MM_MEM_LAT + 3))
      else begin
         fail_count++;
         $error("done not one cycle after the final output");
      end

endmodule

// ==== test/mm_tb.sv ====
`timescale 1ns/10ps
`include "mm_consts.svh"

module mm_tb;

   localparam int LANES = `MM_LANES;
   localparam int AW    = `MM_ADDR_W;
   // beats of each job plus 10, then 50 spare
   localparam int TIMEOUT_CYCLES = (3 * 2 * 2 + 10) + (2 * 3 * 2 + 10)
                                 + (2 * 2 * 3 + 10) + (1 * 1 * 3 + 10) + 50;

   logic                clk;
   logic                rstn;
   mm_pkg::mm_cfg_t     cfg;
   logic                start;
   mm_pkg::rd_req_t     input_rd;
   mm_pkg::vec_rsp_t    input_rsp;
   mm_pkg::rd_req_t     weight_rd;
   mm_pkg::wblock_rsp_t weight_rsp;
   mm_pkg::rd_req_t     bias_rd;
   mm_pkg::vec_rsp_t    bias_rsp;
   logic                out_valid;
   logic [AW-1:0]       out_addr;
   mm_pkg::vec_t        out_data;
   logic                done;

   mm_pkg::vec_t        input_mem [2**`MM_ADDR_W];
   mm_pkg::wblock_t     weight_mem [2**`MM_WADDR_W];
   mm_pkg::vec_t        bias_mem [2**`MM_BADDR_W];
   mm_pkg::rd_req_t     input_q;
   mm_pkg::rd_req_t     weight_q;
   mm_pkg::rd_req_t     bias_q;
   mm_pkg::vec_t        exp_data_q [$];
   logic [AW-1:0]       exp_addr_q [$];
   string               test_name;
   int                  cycles = 0;

   mm_top i_dut (.*);

   bind mm_top mm_checker i_checker (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////
   // memory models, one request stage then the response
   ////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      input_q    <= input_rd;
      weight_q   <= weight_rd;
      bias_q     <= bias_rd;
      input_rsp  <= #1 {input_mem[input_q.addr[`MM_ADDR_W-1:0]], input_q.valid};
      weight_rsp <= #1 {weight_mem[weight_q.addr], weight_q.valid};
      bias_rsp   <= #1 {bias_mem[bias_q.addr[`MM_BADDR_W-1:0]], bias_q.valid};
   end

   task automatic stop_with_failure();
      $display("Test FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   function automatic mm_pkg::mm_cfg_t make_cfg(int in_s, int w_s, int b_s, int out_s,
                                               int ci, int co, int n, bit bias, bit relu);
      mm_pkg::mm_cfg_t c;
      c.input_start  = in_s;
      c.weight_start = w_s;
      c.bias_start   = b_s;
      c.output_start = out_s;
      c.ci_count     = ci;
      c.co_count     = co;
      c.node_count   = n;
      c.bias_en      = bias;
      c.relu_en      = relu;
      return c;
   endfunction

   // sum over ci and i of x[i]*w[i][j], bias, wrap, relu
   function automatic mm_pkg::vec_t expected_vec(mm_pkg::mm_cfg_t c, int n, int co);
      mm_pkg::vec_t    x;
      mm_pkg::wblock_t w;
      mm_pkg::vec_t    r;
      longint          sum;
      for (int j = 0; j < LANES; j++) begin
         sum = 0;
         for (int ci = 0; ci < c.ci_count; ci++) begin
            x = input_mem[c.input_start + n * c.ci_count + ci];
            w = weight_mem[c.weight_start + co * c.ci_count + ci];
            for (int i = 0; i < LANES; i++) begin
               sum += longint'(x[i]) * longint'(w[i][j]);
            end
         end
         if (c.bias_en) begin
            sum += longint'(bias_mem[c.bias_start + co][j]);
         end
         r[j] = sum[`MM_ELEM_W-1:0];
         if (c.relu_en && r[j] < 0) begin
            r[j] = '0;
         end
      end
      return r;
   endfunction

   function automatic bit has_negative(mm_pkg::vec_t v);
      bit neg;
      neg = 1'b0;
      for (int j = 0; j < LANES; j++) begin
         neg |= (v[j] < 0);
      end
      return neg;
   endfunction

   task automatic queue_expected(input mm_pkg::mm_cfg_t c);
      int k;
      k = 0;
      for (int n = 0; n < c.node_count; n++) begin
         for (int co = 0; co < c.co_count; co++) begin
            exp_data_q.push_back(expected_vec(c, n, co));
            exp_addr_q.push_back(AW'(c.output_start + k));
            k++;
         end
      end
   endtask

   // called one edge after reset or right at the edge that shows done
   task automatic run_job(input string name, input mm_pkg::mm_cfg_t c);
      test_name = name;
      queue_expected(c);
      #1;
      cfg   = c;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      do @(posedge clk); while (!done);
      assert (exp_data_q.size() == 0) else begin
         $display("ERROR %s: expected 0 outputs left, actual %0d", name, exp_data_q.size());
         stop_with_failure();
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // output checks against the model queue
   ////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      mm_pkg::vec_t  exp_data;
      logic [AW-1:0] exp_addr;
      if (rstn && out_valid) begin
         if (exp_data_q.size() == 0) begin
            $display("%s: output at address %0d with no output expected", test_name, out_addr);
            stop_with_failure();
         end else begin
            exp_data = exp_data_q.pop_front();
            exp_addr = exp_addr_q.pop_front();
            assert (out_addr == exp_addr) begin
               assert (out_data == exp_data && !(cfg.relu_en && has_negative(out_data)))
               else begin
                  $display("ERROR %s: expected data %h, actual %h", test_name, exp_data,
                           out_data);
                  stop_with_failure();
               end
            end else begin
               $display("ERROR %s: expected address %0d, actual %0d", test_name, exp_addr,
                        out_addr);
               stop_with_failure();
            end
         end
      end
   end

   // checker assertions and the cycle limit
   always @(posedge clk) begin
      cycles++;
      if (i_dut.i_checker.fail_count != 0) begin
         $display("a checker assertion failed in %s", test_name);
         stop_with_failure();
      end else if (cycles > TIMEOUT_CYCLES) begin
         $display("timeout in %s after %0d cycles", test_name, cycles);
         stop_with_failure();
      end
   end

   initial begin
      void'($urandom(32'h271c601b));
      rstn       = 1'b0;
      start      = 1'b0;
      cfg        = '0;
      input_rsp  = '0;
      weight_rsp = '0;
      bias_rsp   = '0;
      input_q    = '0;
      weight_q   = '0;
      bias_q     = '0;
      test_name  = "reset";
      foreach (input_mem[a]) begin
         input_mem[a] = {$urandom, $urandom};
      end
      foreach (weight_mem[a]) begin
         for (int r = 0; r < LANES; r++) begin
            weight_mem[a][r] = {$urandom, $urandom};
         end
      end
      foreach (bias_mem[a]) begin
         bias_mem[a] = {$urandom, $urandom};
      end
      repeat (5) @(posedge clk);
      #1;
      rstn = 1'b1;
      @(posedge clk);
      run_job("walk_plain", make_cfg(16, 40, 0, 100, 3, 2, 2, 1'b0, 1'b0));
      run_job("bias", make_cfg(200, 300, 20, 300, 2, 3, 2, 1'b1, 1'b0));
      run_job("relu", make_cfg(400, 500, 60, 500, 2, 2, 3, 1'b1, 1'b1));
      // starts the cycle after done
      run_job("back_to_back", make_cfg(700, 900, 0, 1000, 1, 1, 3, 1'b0, 1'b0));
      // done cycle and the one after it still go through the checker
      repeat (2) @(posedge clk);
      if (i_dut.i_checker.fail_count != 0) begin
         stop_with_failure();
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule
